/* common/decodeBus.sv */
interface decodeBus import frontPkg::*; ();

  // decoded word, never an imm prefix
  logic      valid;
  instWord_u inst;
  // sign-extended or merged with the prefix
  logic [31:0] immVal;
  logic [31:0] pc;
  // word was replaced by the interrupt branch
  logic      isInterrupt;

  modport source (
    output valid, inst, immVal, pc, isInterrupt
  );

  modport sink (
    input valid, inst, immVal, pc, isInterrupt
  );

endinterface

/* common/fetchBus.sv */
interface fetchBus import frontPkg::*; ();

  // single-cycle strobe, no back-pressure
  logic      valid;
  // word and its pc, only meaningful with valid
  instWord_u inst;
  logic [31:0] pc;

  modport source (
    output valid, inst, pc
  );

  modport sink (
    input valid, inst, pc
  );

endinterface

/* common/frontPkg.sv */
package frontPkg;

  // register-register layout
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [10:0] alt;
  } instTypeA_s;

  // register-immediate layout
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [15:0] imm;
  } instTypeB_s;

  // one fetched word, read through either layout
  typedef union packed {
    instTypeA_s a;
    instTypeB_s b;
  } instWord_u;

  // alu opcodes, bit 3 set means immediate form
  localparam logic [5:0] opAdd   = 6'o00;
  localparam logic [5:0] opRsub  = 6'o01;
  localparam logic [5:0] opAddi  = 6'o10;
  localparam logic [5:0] opRsubi = 6'o11;
  localparam logic [5:0] opOr    = 6'o40;
  localparam logic [5:0] opAnd   = 6'o41;
  localparam logic [5:0] opXor   = 6'o42;
  localparam logic [5:0] opOri   = 6'o50;
  localparam logic [5:0] opAndi  = 6'o51;
  localparam logic [5:0] opXori  = 6'o52;

  // flow control and prefix
  localparam logic [5:0] opBr    = 6'o46;
  localparam logic [5:0] opBcc   = 6'o57;
  localparam logic [5:0] opBri   = 6'o56;
  localparam logic [5:0] opImm   = 6'o54;
  localparam logic [5:0] opRtsd  = 6'o55;

  // flag positions inside the ra field of br/bri
  localparam int linkBit = 2;
  localparam int absBit  = 3;

  // bcc conditions, low bits of rd
  localparam logic [2:0] condEq = 3'd0;
  localparam logic [2:0] condNe = 3'd1;

  // interrupt entry
  localparam logic [31:0] intVector  = 32'h0000_0060;
  localparam logic [4:0]  intLinkReg = 5'd14;
  localparam logic [4:0]  intFlags   = 5'(1 << linkBit) | 5'(1 << absBit);
  // bri r14, absolute and linking, to the vector
  localparam logic [31:0] intOpWord  = {opBri, intLinkReg, intFlags, intVector[15:0]};

endpackage

/* execStage/execStage.sv */
module execStage import frontPkg::*; (
  input  logic        gclk,
  input  logic        rstN,
  decodeBus.sink      db,
  output logic        wbValid,
  output logic [4:0]  wbRd,
  output logic [31:0] wbData,
  output logic        branchTaken,
  output logic [31:0] branchTarget
);

  logic [31:0] regFile [32];
  logic [31:0] raVal;
  logic [31:0] rbVal;
  // second operand, register or immediate
  logic [31:0] opndB;
  logic [5:0]  opc;
  logic [31:0] result;
  logic [31:0] target;
  logic        writes;
  logic        taken;

  assign opc = db.inst.a.opcode;

  // r0 reads as zero whatever was written
  assign raVal = (db.inst.a.ra == 5'd0) ? '0 : regFile[db.inst.a.ra];
  assign rbVal = (db.inst.a.rb == 5'd0) ? '0 : regFile[db.inst.a.rb];

  // bit 3 of the opcode marks the immediate form
  assign opndB = opc[3] ? db.immVal : rbVal;

  always_comb begin
    result = '0;
    target = '0;
    writes = 1'b0;
    taken  = 1'b0;
    case (opc)
      opAdd, opAddi: begin
        result = raVal + opndB;
        writes = 1'b1;
      end
      // reverse subtract
      opRsub, opRsubi: begin
        result = opndB - raVal;
        writes = 1'b1;
      end
      opOr, opOri: begin
        result = raVal | opndB;
        writes = 1'b1;
      end
      opAnd, opAndi: begin
        result = raVal & opndB;
        writes = 1'b1;
      end
      opXor, opXori: begin
        result = raVal ^ opndB;
        writes = 1'b1;
      end
      opBr, opBri: begin
        taken  = 1'b1;
        target = db.inst.a.ra[absBit] ? opndB : db.pc + opndB;
        // link saves the branch's own pc
        result = db.pc;
        writes = db.inst.a.ra[linkBit];
      end
      opBcc: begin
        target = db.pc + db.immVal;
        case (db.inst.a.rd[2:0])
          condEq:  taken = (raVal == '0);
          condNe:  taken = (raVal != '0);
          default: taken = 1'b0;
        endcase
      end
      opRtsd: begin
        taken  = 1'b1;
        target = raVal + db.immVal;
      end
      default: begin
        writes = 1'b0;
      end
    endcase
  end

  // write lands on the same edge as wbValid, next decode sees it
  always_ff @(posedge gclk) begin
    if (db.valid && writes) begin
      regFile[db.inst.a.rd] <= result;
    end
  end

  always_ff @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      wbValid     <= 1'b0;
      branchTaken <= 1'b0;
    end else begin
      wbValid     <= db.valid && writes;
      branchTaken <= db.valid && taken;
    end
  end

  always_ff @(posedge gclk) begin
    if (db.valid) begin
      wbRd         <= db.inst.a.rd;
      wbData       <= result;
      branchTarget <= target;
    end
  end

endmodule

/* instBuffer/instBuffer.sv */
module instBuffer import frontPkg::*; (
  input  logic gclk,
  input  logic rstN,
  input  logic intReq,
  input  logic intEnable,
  input  logic branchTaken,
  fetchBus.sink     fb,
  decodeBus.source  db
);

  // interrupt sampling and pending latch
  logic [1:0]  intSync;
  logic        intLatch;
  // branch shadow of the decode and execute slots
  logic        dBranch;
  logic        xBranch;
  // imm prefix waiting for its follower
  logic        immPending;
  logic [15:0] immHi;
  logic        shadowBlock;
  logic        doInject;
  // word actually sent to decode
  instWord_u   selWord;
  logic [31:0] selImm;
  logic        selIsImm;
  logic        selIsBranch;

  function automatic logic isBranchOp(input logic [5:0] opc);
    return opc inside {opBr, opBri, opBcc, opRtsd};
  endfunction

  // unresolved branch ahead, injection would land in its shadow
  assign shadowBlock = (dBranch || xBranch) && !branchTaken;

  // never split an imm pair
  assign doInject = intLatch && intEnable && fb.valid && !shadowBlock && !immPending;

  // displaced word is dropped, its pc is kept for the link
  assign selWord = doInject ? instWord_u'(intOpWord) : fb.inst;

  assign selIsImm    = (selWord.b.opcode == opImm);
  assign selIsBranch = isBranchOp(selWord.a.opcode);

  // follower of a prefix takes the upper half from it
  assign selImm = immPending ? {immHi, selWord.b.imm}
                             : {{16{selWord.b.imm[15]}}, selWord.b.imm};

  always_ff @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      intSync  <= '0;
      intLatch <= 1'b0;
    end else begin
      // sampling frozen while interrupts are off
      if (intEnable) begin
        intSync <= {intSync[0], intReq};
      end
      if (!intEnable) begin
        intLatch <= 1'b0;
      end else if (doInject) begin
        // injected word enters decode on this edge
        intLatch <= 1'b0;
      end else if (intSync[1]) begin
        intLatch <= 1'b1;
      end
    end
  end

  always_ff @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      db.valid       <= 1'b0;
      db.isInterrupt <= 1'b0;
      dBranch        <= 1'b0;
      xBranch        <= 1'b0;
      immPending     <= 1'b0;
    end else begin
      // prefix is swallowed here
      db.valid       <= fb.valid && !selIsImm;
      db.isInterrupt <= doInject;
      dBranch        <= fb.valid && selIsBranch;
      xBranch        <= dBranch;
      // any fetched word ends the pair, a new prefix starts one
      if (fb.valid) begin
        immPending <= selIsImm;
      end
    end
  end

  always_ff @(posedge gclk) begin
    if (fb.valid) begin
      db.inst   <= selWord;
      db.immVal <= selImm;
      db.pc     <= fb.pc;
      if (selIsImm) begin
        immHi <= selWord.b.imm;
      end
    end
  end

endmodule

/* logic/cpuFrontEnd.sv */
module cpuFrontEnd (
  input  logic        gclk,
  input  logic        rstN,
  input  logic        instrValid,
  input  logic [31:0] instrWord,
  input  logic        intReq,
  input  logic        intEnable,
  output logic        wbValid,
  output logic [4:0]  wbRd,
  output logic [31:0] wbData,
  output logic        branchTaken,
  output logic [31:0] branchTarget
);

  // fetch to buffer
  fetchBus  fetchIf ();
  // buffer to execute
  decodeBus decodeIf ();

  // pc and word registration
  fetchStage fetchStage_i (
    .gclk         (gclk),
    .rstN         (rstN),
    .instrValid   (instrValid),
    .instrWord    (instrWord),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .fb           (fetchIf)
  );

  // decode, imm merge, interrupt injection
  instBuffer instBuffer_i (
    .gclk        (gclk),
    .rstN        (rstN),
    .intReq      (intReq),
    .intEnable   (intEnable),
    .branchTaken (branchTaken),
    .fb          (fetchIf),
    .db          (decodeIf)
  );

  // branch outputs also feed back to fetch and buffer
  execStage execStage_i (
    .gclk         (gclk),
    .rstN         (rstN),
    .db           (decodeIf),
    .wbValid      (wbValid),
    .wbRd         (wbRd),
    .wbData       (wbData),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget)
  );

endmodule

/* logic/fetchStage.sv */
module fetchStage (
  input  logic        gclk,
  input  logic        rstN,
  input  logic        instrValid,
  input  logic [31:0] instrWord,
  input  logic        branchTaken,
  input  logic [31:0] branchTarget,
  fetchBus.source     fb
);

  // pc the next strobed word gets without a redirect
  logic [31:0] nextPc;
  // pc of the word strobed this cycle
  logic [31:0] wordPc;

  // redirect only hits the word strobed in the resolving cycle
  assign wordPc = branchTaken ? branchTarget : nextPc;

  always_ff @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      nextPc   <= '0;
      fb.valid <= 1'b0;
    end else begin
      // strobe lasts exactly one cycle on the bus
      fb.valid <= instrValid;
      if (instrValid) begin
        nextPc <= wordPc + 32'd4;
      end
    end
  end

  // payload held until the next strobe
  always_ff @(posedge gclk) begin
    if (instrValid) begin
      fb.inst <= instrWord;
      fb.pc   <= wordPc;
    end
  end

endmodule

/* project.f */
common/frontPkg.sv
common/fetchBus.sv
common/decodeBus.sv
logic/fetchStage.sv
instBuffer/instBuffer.sv
execStage/execStage.sv
logic/cpuFrontEnd.sv
tests/cpuFrontEnd_checker.sv
tests/cpuFrontEndTb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module cpuFrontEndTb -f project.f -o simv \
  > build.log 2>&1 && ./obj_dir/simv > sim.log 2>&1 || { cat build.log sim.log; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0

/* tests/cpuFrontEndTb.sv */
module cpuFrontEndTb import frontPkg::*; ();

  typedef struct packed {
    logic        writes;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        taken;
    logic [31:0] target;
  } refResult_s;

  logic        gclk;
  logic        rstN;
  logic        instrValid;
  logic [31:0] instrWord;
  logic        intReq;
  logic        intEnable;
  logic        wbValid;
  logic [4:0]  wbRd;
  logic [31:0] wbData;
  logic        branchTaken;
  logic [31:0] branchTarget;

  integer seed = 32'h400d;
  // cycle limit for the whole run
  int cycleLimit = 2000;
  int cycles = 0;
  int errCount = 0;
  int checkCount = 0;
  int testCount = 0;
  string curTest = "reset";

  // model state
  logic [31:0] refRegs [32];
  logic [31:0] nextPc = '0;
  // targets of taken branches, keyed by strobe cycle
  logic [31:0] takenTarget [int];
  logic        immPend = 1'b0;
  logic [15:0] immHi = '0;
  refResult_s  expQ [$];
  string       nameQ [$];

  logic [5:0] aluOps [10] = '{opAdd, opRsub, opAddi, opRsubi, opOr,
                              opAnd, opXor, opOri, opAndi, opXori};

  cpuFrontEnd cpuFrontEnd_i (
    .gclk         (gclk),
    .rstN         (rstN),
    .instrValid   (instrValid),
    .instrWord    (instrWord),
    .intReq       (intReq),
    .intEnable    (intEnable),
    .wbValid      (wbValid),
    .wbRd         (wbRd),
    .wbData       (wbData),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget)
  );

  bind cpuFrontEnd cpuFrontEnd_checker checker_i (
    .gclk      (gclk),
    .rstN      (rstN),
    .fbValid   (fetchIf.valid),
    .fbOpcode  (fetchIf.inst.b.opcode),
    .dbValid   (decodeIf.valid),
    .dbIsInt   (decodeIf.isInterrupt),
    .intEnable (intEnable),
    .wbValid   (wbValid)
  );

  initial gclk = 1'b0;
  always #20 gclk = ~gclk;

  always @(posedge gclk) begin
    cycles = cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout after %0d cycles in test %s, outputs never drained", cycles, curTest);
      $display("Something failed");
      $finish;
    end
  end

  function automatic logic [31:0] typeA(input logic [5:0] op, input logic [4:0] rd,
                                        input logic [4:0] ra, input logic [4:0] rb);
    return {op, rd, ra, rb, 11'd0};
  endfunction

  function automatic logic [31:0] typeB(input logic [5:0] op, input logic [4:0] rd,
                                        input logic [4:0] ra, input logic [15:0] imm);
    return {op, rd, ra, imm};
  endfunction

  // expected writeback and branch of one executed word
  function automatic refResult_s refExec(input logic [31:0] w, input logic [31:0] pc,
                                         input logic [31:0] immV);
    refResult_s r;
    logic [5:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] opnd;
    op = w[31:26];
    a = (w[20:16] == 5'd0) ? '0 : refRegs[w[20:16]];
    b = (w[15:11] == 5'd0) ? '0 : refRegs[w[15:11]];
    opnd = (op inside {opAddi, opRsubi, opOri, opAndi, opXori, opBri}) ? immV : b;
    r = '0;
    r.rd = w[25:21];
    case (op)
      opAdd, opAddi: {r.writes, r.data} = {1'b1, a + opnd};
      opRsub, opRsubi: {r.writes, r.data} = {1'b1, opnd - a};
      opOr, opOri: {r.writes, r.data} = {1'b1, a | opnd};
      opAnd, opAndi: {r.writes, r.data} = {1'b1, a & opnd};
      opXor, opXori: {r.writes, r.data} = {1'b1, a ^ opnd};
      opBr, opBri: begin
        r.taken = 1'b1;
        r.target = w[16 + absBit] ? opnd : pc + opnd;
        r.writes = w[16 + linkBit];
        r.data = pc;
      end
      opBcc: begin
        r.target = pc + immV;
        if (w[23:21] == condEq) r.taken = (a == '0);
        else if (w[23:21] == condNe) r.taken = (a != '0);
      end
      opRtsd: begin
        r.taken = 1'b1;
        r.target = a + immV;
      end
      default: r.writes = 1'b0;
    endcase
    return r;
  endfunction

  task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
    checkCount++;
    if (exp !== act) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      errCount++;
    end
  endtask

  // starts and ends on a falling edge
  task automatic issueWord(input string name, input logic [31:0] w, input int gap,
                           input bit displaced, input bit raiseInt);
    logic [31:0] pc;
    logic [31:0] word;
    logic [31:0] immV;
    refResult_s  r;
    // a taken branch strobed three cycles earlier redirects this word
    pc = takenTarget.exists(cycles - 3) ? takenTarget[cycles - 3] : nextPc;
    word = displaced ? intOpWord : w;
    immV = immPend ? {immHi, word[15:0]} : {{16{word[15]}}, word[15:0]};
    if (word[31:26] == opImm) begin
      immPend = 1'b1;
      immHi = word[15:0];
    end else begin
      immPend = 1'b0;
      r = refExec(word, pc, immV);
      if (r.writes) refRegs[r.rd] = r.data;
      if (r.writes || r.taken) begin
        expQ.push_back(r);
        nameQ.push_back(name);
      end
      if (r.taken) takenTarget[cycles] = r.target;
    end
    nextPc = pc + 32'd4;
    instrValid = 1'b1;
    instrWord = w;
    if (raiseInt) intReq = 1'b1;
    @(negedge gclk);
    instrValid = 1'b0;
    intReq = 1'b0;
    repeat (gap - 1) @(negedge gclk);
  endtask

  // one-cycle request plus time for sync flops and latch
  task automatic pulseInt();
    intReq = 1'b1;
    @(negedge gclk);
    intReq = 1'b0;
    repeat (3) @(negedge gclk);
  endtask

  task automatic finishTest();
    while (expQ.size() != 0) @(negedge gclk);
    repeat (2) @(negedge gclk);
    testCount++;
    $display("test %s finished, %0d errors so far", curTest, errCount);
  endtask

  // compare each output cycle against the oldest expectation
  always @(negedge gclk) begin
    refResult_s e;
    string n;
    if (rstN && (wbValid || branchTaken)) begin
      if (expQ.size() == 0) begin
        $display("unexpected writeback or branch in test %s", curTest);
        errCount++;
      end else begin
        e = expQ.pop_front();
        n = nameQ.pop_front();
        checkVal({n, " wbValid"}, 32'(e.writes), 32'(wbValid));
        checkVal({n, " branchTaken"}, 32'(e.taken), 32'(branchTaken));
        if (e.writes) begin
          checkVal({n, " wbRd"}, 32'(e.rd), 32'(wbRd));
          checkVal({n, " wbData"}, e.data, wbData);
        end
        if (e.taken) checkVal({n, " branchTarget"}, e.target, branchTarget);
      end
    end
  end

  initial begin
    logic [5:0] op;
    logic [4:0] rd;
    logic [4:0] ra;
    logic [4:0] rb;
    rstN = 1'b0;
    instrValid = 1'b0;
    instrWord = '0;
    intReq = 1'b0;
    intEnable = 1'b1;
    foreach (refRegs[i]) refRegs[i] = '0;
    repeat (4) @(negedge gclk);
    rstN = 1'b1;

    repeat (6) begin
      checkVal("reset wbValid", 32'd0, 32'(wbValid));
      checkVal("reset branchTaken", 32'd0, 32'(branchTaken));
      @(negedge gclk);
    end
    finishTest();

    curTest = "random alu";
    for (int i = 1; i <= 8; i++) begin
      issueWord("init ori", typeB(opOri, 5'(i), 5'd0, 16'($random(seed))), 1, 0, 0);
    end
    for (int i = 0; i < 20; i++) begin
      op = aluOps[$unsigned($random(seed)) % 10];
      rd = 5'(1 + $unsigned($random(seed)) % 8);
      ra = 5'(1 + $unsigned($random(seed)) % 8);
      rb = 5'(1 + $unsigned($random(seed)) % 8);
      // bit 3 of the opcode marks the immediate forms
      if (op[3]) issueWord("random alu", typeB(op, rd, ra, 16'($random(seed))), 1, 0, 0);
      else issueWord("random alu", typeA(op, rd, ra, rb), 1, 0, 0);
    end
    finishTest();

    curTest = "imm merge";
    issueWord("imm prefix", typeB(opImm, 5'd0, 5'd0, 16'hABCD), 1, 0, 0);
    issueWord("merged addi", typeB(opAddi, 5'd9, 5'd1, 16'h1234), 3, 0, 0);
    finishTest();

    curTest = "branches";
    issueWord("bri relative", typeB(opBri, 5'd0, 5'b00000, 16'h0020), 3, 0, 0);
    issueWord("bri link", typeB(opBri, 5'd15, 5'b00100, 16'h0040), 3, 0, 0);
    issueWord("bri abs link", typeB(opBri, 5'd16, 5'b01100, 16'h0200), 3, 0, 0);
    issueWord("br reg link", typeA(opBr, 5'd17, 5'b00100, 5'd3), 3, 0, 0);
    issueWord("bcc eq taken", typeB(opBcc, 5'(condEq), 5'd0, 16'h0010), 3, 0, 0);
    issueWord("bcc ne untaken", typeB(opBcc, 5'(condNe), 5'd0, 16'h0010), 3, 0, 0);
    issueWord("rtsd", typeB(opRtsd, 5'd0, 5'd16, 16'h0008), 3, 0, 0);
    issueWord("link probe", typeB(opBri, 5'd18, 5'b01100, 16'h0300), 3, 0, 0);
    finishTest();

    curTest = "interrupt";
    pulseInt();
    issueWord("displaced word", typeB(opAddi, 5'd9, 5'd1, 16'h0011), 3, 1, 0);
    issueWord("vector word", typeB(opOri, 5'd10, 5'd0, 16'h0055), 3, 0, 0);
    issueWord("vector probe", typeB(opBri, 5'd19, 5'b00100, 16'h0004), 3, 0, 0);
    intEnable = 1'b0;
    pulseInt();
    issueWord("masked word", typeB(opAddi, 5'd11, 5'd2, 16'h0007), 3, 0, 0);
    issueWord("masked next", typeB(opXori, 5'd11, 5'd11, 16'h00F0), 3, 0, 0);
    intEnable = 1'b1;
    finishTest();

    curTest = "blocked interrupt";
    issueWord("shadow bcc", typeB(opBcc, 5'(condNe), 5'd0, 16'h0010), 1, 0, 1);
    issueWord("shadow w2", typeB(opAddi, 5'd12, 5'd1, 16'h0001), 1, 0, 0);
    issueWord("shadow w3", typeB(opAddi, 5'd13, 5'd2, 16'h0002), 1, 0, 0);
    issueWord("shadow displaced", typeB(opAddi, 5'd20, 5'd3, 16'h0003), 3, 1, 0);
    issueWord("shadow probe", typeB(opBri, 5'd21, 5'b00100, 16'h0004), 3, 0, 0);
    issueWord("pair prefix", typeB(opImm, 5'd0, 5'd0, 16'h1357), 3, 0, 1);
    issueWord("pair follower", typeB(opAddi, 5'd22, 5'd1, 16'h2468), 1, 0, 0);
    issueWord("pair displaced", typeB(opAddi, 5'd23, 5'd4, 16'h0005), 3, 1, 0);
    issueWord("pair probe", typeB(opBri, 5'd24, 5'b00100, 16'h0004), 3, 0, 0);
    finishTest();

    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* tests/cpuFrontEnd_checker.sv */
module cpuFrontEnd_checker import frontPkg::*; (
  input logic       gclk,
  input logic       rstN,
  input logic       fbValid,
  input logic [5:0] fbOpcode,
  input logic       dbValid,
  input logic       dbIsInt,
  input logic       intEnable,
  input logic       wbValid
);

  // writeback one cycle behind its decode
  assert property (@(posedge gclk) disable iff (!rstN)
    wbValid |-> $past(dbValid))
    else $error("writeback without a decode valid one cycle earlier");

  // prefix is swallowed unless the interrupt replaced it
  assert property (@(posedge gclk) disable iff (!rstN)
    (fbValid && fbOpcode == opImm) |=> (!dbValid || dbIsInt))
    else $error("decode valid after an imm prefix fetch");

  // no injection with interrupts off
  assert property (@(posedge gclk) disable iff (!rstN)
    dbIsInt |-> $past(intEnable))
    else $error("interrupt injected while intEnable was low");

endmodule
